//--- design/cpuPkg.sv
`default_nettype none

package cpuPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;
	localparam int IMEM_DEPTH = 64; // words
	localparam int DMEM_DEPTH = 64; // words
	localparam int IMEM_ADDR_W = 6;
	localparam int DMEM_ADDR_W = 6;

	// MIPS primary opcodes
	typedef enum logic [5:0] {
		OP_RTYPE = 6'd0,
		OP_ADDI = 6'd8,
		OP_LW = 6'd35,
		OP_SW = 6'd43
	} opcode_e;

	// funct field of R-type words
	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOp_e;

	typedef enum logic [1:0] {FWD_NONE, FWD_EXMEM, FWD_MEMWB} fwdSel_e;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg; // write back the load data, not the ALU result
		logic aluSrc; // operand B from the immediate
		aluOp_e aluOp;
		logic [REG_ADDR_W-1:0] destReg;
	} ctrl_t;

	typedef struct packed {
		logic [XLEN-1:0] instr;
	} ifId_t;

	typedef struct packed {
		ctrl_t ctrl;
		logic [REG_ADDR_W-1:0] rs;
		logic [REG_ADDR_W-1:0] rt;
		logic [XLEN-1:0] a; // rs value
		logic [XLEN-1:0] b; // rt value
		logic [XLEN-1:0] imm; // sign extended
	} idEx_t;

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0] aluOut;
		logic [XLEN-1:0] storeData;
	} exMem_t;

	typedef struct packed {
		logic regWrite;
		logic memToReg;
		logic [REG_ADDR_W-1:0] destReg;
		logic [XLEN-1:0] aluOut;
		logic [XLEN-1:0] loadData;
	} memWb_t;

	// write-back observation port
	typedef struct packed {
		logic valid;
		logic [REG_ADDR_W-1:0] regAddr;
		logic [XLEN-1:0] data;
	} wbPort_t;

	// instruction memory load port, used while in reset
	typedef struct packed {
		logic we;
		logic [IMEM_ADDR_W-1:0] addr;
		logic [XLEN-1:0] data;
	} progWrite_t;

	// value written back by the instruction in MEM/WB
	function automatic logic [XLEN-1:0] wbValue(input memWb_t w);
		return w.memToReg ? w.loadData : w.aluOut;
	endfunction

endpackage

`default_nettype wire

//--- design/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
	input logic clk,
	input logic rst,
	input cpuPkg::progWrite_t progLoad,
	input logic stall,
	output cpuPkg::ifId_t ifId
);
	import cpuPkg::*;

	logic [XLEN-1:0] pc; // byte address
	logic [IMEM_ADDR_W-1:0] pcIdx;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] imem [IMEM_DEPTH];

	assign pcIdx = pc[IMEM_ADDR_W+1:2]; // word index
	assign instr = imem[pcIdx]; // async read

	// PC counter
	always_ff @(posedge clk)
	begin
		if (rst)
			pc <= '0;
		else if (!stall)
			pc <= pc + XLEN'(4);
	end

	// program image written only while the core is held in reset
	always_ff @(posedge clk)
	begin
		if (rst && progLoad.we)
			imem[progLoad.addr] <= progLoad.data;
	end

	// IF/ID register
	always_ff @(posedge clk)
	begin
		if (rst)
			ifId.instr <= '0; // nop
		else if (!stall) // load-use: hold
			ifId.instr <= instr;
	end

	// loader must finish before reset is released
	assert property (@(posedge clk) progLoad.we |-> rst);

	// programs never run past the end of instruction memory
	assert property (@(posedge clk) disable iff (rst) pc < XLEN'(IMEM_DEPTH * 4));

endmodule

`default_nettype wire

//--- design/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input logic clk,
	input logic rst,
	input cpuPkg::ifId_t ifId,
	input logic stall,
	input cpuPkg::memWb_t memWb,
	output cpuPkg::idEx_t idEx
);
	import cpuPkg::*;

	opcode_e opcode;
	funct_e funct;
	logic [REG_ADDR_W-1:0] rs, rt, rd;
	logic [XLEN-1:0] imm;
	logic [XLEN-1:0] rdA, rdB;
	ctrl_t ctrl;
	logic knownInstr; // one of the eight supported instructions
	logic [XLEN-1:0] regs [32];

	// instruction fields
	assign opcode = opcode_e'(ifId.instr[31:26]);
	assign funct = funct_e'(ifId.instr[5:0]);
	assign rs = ifId.instr[25:21];
	assign rt = ifId.instr[20:16];
	assign rd = ifId.instr[15:11];
	assign imm = {{(XLEN-16){ifId.instr[15]}}, ifId.instr[15:0]};

	assign knownInstr = (opcode inside {OP_ADDI, OP_LW, OP_SW}) ||
		(opcode == OP_RTYPE && (funct inside {FN_ADD, FN_SUB, FN_AND, FN_OR, FN_SLT}));

	// control decode
	always_comb
	begin
		ctrl = '0; // nop unless recognized
		case (opcode)
			OP_RTYPE:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.destReg = rd;
				case (funct)
					FN_ADD: ctrl.aluOp = ALU_ADD;
					FN_SUB: ctrl.aluOp = ALU_SUB;
					FN_AND: ctrl.aluOp = ALU_AND;
					FN_OR: ctrl.aluOp = ALU_OR;
					FN_SLT: ctrl.aluOp = ALU_SLT;
					default:
					begin
						ctrl.regWrite = 1'b0; // includes the all-zero nop
						ctrl.destReg = '0;
					end
				endcase
			end
			OP_ADDI:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
				ctrl.destReg = rt;
			end
			OP_LW:
			begin
				ctrl.regWrite = 1'b1;
				ctrl.memRead = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc = 1'b1; // base + offset
				ctrl.destReg = rt;
			end
			OP_SW:
			begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc = 1'b1;
			end
			default: ctrl = '0;
		endcase
	end

	// register file with r0 never written
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (memWb.regWrite && memWb.destReg != '0)
			regs[memWb.destReg] <= wbValue(memWb);
	end

	// read ports with write-through of the value being written back this cycle
	always_comb
	begin
		rdA = regs[rs];
		rdB = regs[rt];
		if (memWb.regWrite && memWb.destReg != '0 && memWb.destReg == rs)
			rdA = wbValue(memWb);
		if (memWb.regWrite && memWb.destReg != '0 && memWb.destReg == rt)
			rdB = wbValue(memWb);
		if (rs == '0)
			rdA = '0;
		if (rt == '0)
			rdB = '0;
	end

	// ID/EX register
	always_ff @(posedge clk)
	begin
		idEx.rs <= rs;
		idEx.rt <= rt;
		idEx.a <= rdA;
		idEx.b <= rdB;
		idEx.imm <= imm;
		if (rst || stall)
			idEx.ctrl <= '0; // bubble
		else
			idEx.ctrl <= ctrl;
	end

	// write enables in ID/EX only for a decoded word that was not stalled
	assert property (@(posedge clk) disable iff (rst)
		(idEx.ctrl.regWrite || idEx.ctrl.memWrite) |-> $past(knownInstr && !stall));

endmodule

`default_nettype wire

//--- design/hazardUnit.sv
`timescale 1ns/1ns
`default_nettype none

module hazardUnit (
	input cpuPkg::idEx_t idEx,
	input cpuPkg::ifId_t ifId,
	input cpuPkg::exMem_t exMem,
	input cpuPkg::memWb_t memWb,
	output logic stall,
	output cpuPkg::fwdSel_e fwdA,
	output cpuPkg::fwdSel_e fwdB
);
	import cpuPkg::*;

	logic [REG_ADDR_W-1:0] nextRs, nextRt; // fields of the word in IF/ID

	// newest producer wins; r0 and non-writing stages never forward
	function automatic fwdSel_e pickFwd(input logic [REG_ADDR_W-1:0] src);
		if (exMem.regWrite && exMem.destReg != '0 && exMem.destReg == src)
			return FWD_EXMEM;
		if (memWb.regWrite && memWb.destReg != '0 && memWb.destReg == src)
			return FWD_MEMWB; // covers load data too
		return FWD_NONE;
	endfunction

	assign nextRs = ifId.instr[25:21];
	assign nextRt = ifId.instr[20:16];

	// load in EX feeding the word in ID, one bubble
	always_comb
	begin
		stall = idEx.ctrl.memRead && idEx.ctrl.destReg != '0 &&
			(idEx.ctrl.destReg == nextRs || idEx.ctrl.destReg == nextRt);
	end

	always_comb
	begin
		fwdA = pickFwd(idEx.rs);
		fwdB = pickFwd(idEx.rt); // also feeds store data
	end

endmodule

`default_nettype wire

//--- design/executeStage.sv
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input logic clk,
	input logic rst,
	input cpuPkg::idEx_t idEx,
	input cpuPkg::fwdSel_e fwdA,
	input cpuPkg::fwdSel_e fwdB,
	input cpuPkg::memWb_t memWb,
	output cpuPkg::exMem_t exMem
);
	import cpuPkg::*;

	logic [XLEN-1:0] opA, opB;
	logic [XLEN-1:0] rtVal; // forwarded rt, before the immediate mux
	logic [XLEN-1:0] aluOut;

	// forwarding muxes
	always_comb
	begin
		case (fwdA)
			FWD_EXMEM: opA = exMem.aluOut;
			FWD_MEMWB: opA = wbValue(memWb);
			default: opA = idEx.a;
		endcase
		case (fwdB)
			FWD_EXMEM: rtVal = exMem.aluOut;
			FWD_MEMWB: rtVal = wbValue(memWb);
			default: rtVal = idEx.b;
		endcase
	end

	assign opB = idEx.ctrl.aluSrc ? idEx.imm : rtVal;

	// ALU
	always_comb
	begin
		case (idEx.ctrl.aluOp)
			ALU_SUB: aluOut = opA - opB;
			ALU_AND: aluOut = opA & opB;
			ALU_OR: aluOut = opA | opB;
			ALU_SLT: aluOut = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
			default: aluOut = opA + opB; // add, addi, address calc
		endcase
	end

	// EX/MEM register
	always_ff @(posedge clk)
	begin
		exMem.aluOut <= aluOut;
		exMem.storeData <= rtVal;
		if (rst)
		begin
			exMem.regWrite <= 1'b0;
			exMem.memRead <= 1'b0;
			exMem.memWrite <= 1'b0;
			exMem.memToReg <= 1'b0;
			exMem.destReg <= '0;
		end
		else
		begin
			exMem.regWrite <= idEx.ctrl.regWrite;
			exMem.memRead <= idEx.ctrl.memRead;
			exMem.memWrite <= idEx.ctrl.memWrite;
			exMem.memToReg <= idEx.ctrl.memToReg;
			exMem.destReg <= idEx.ctrl.destReg;
		end
	end

	// hazard unit only forwards from a stage that writes a register
	assert property (@(posedge clk) disable iff (rst)
		(fwdA == FWD_EXMEM || fwdB == FWD_EXMEM) |-> exMem.regWrite);
	assert property (@(posedge clk) disable iff (rst)
		(fwdA == FWD_MEMWB || fwdB == FWD_MEMWB) |-> memWb.regWrite);

endmodule

`default_nettype wire

//--- design/memoryStage.sv
`timescale 1ns/1ns
`default_nettype none

module memoryStage (
	input logic clk,
	input logic rst,
	input cpuPkg::exMem_t exMem,
	output cpuPkg::memWb_t memWb,
	output cpuPkg::wbPort_t wbOut
);
	import cpuPkg::*;

	logic [DMEM_ADDR_W-1:0] dIdx;
	logic [XLEN-1:0] loadData;
	logic [XLEN-1:0] dmem [DMEM_DEPTH];

	assign dIdx = exMem.aluOut[DMEM_ADDR_W-1:0]; // word index
	assign loadData = dmem[dIdx]; // combinational read

	always_ff @(posedge clk)
	begin
		if (exMem.memWrite)
			dmem[dIdx] <= exMem.storeData;
	end

	// MEM/WB register
	always_ff @(posedge clk)
	begin
		memWb.aluOut <= exMem.aluOut;
		memWb.loadData <= loadData;
		if (rst)
		begin
			memWb.regWrite <= 1'b0;
			memWb.memToReg <= 1'b0;
			memWb.destReg <= '0;
		end
		else
		begin
			memWb.regWrite <= exMem.regWrite;
			memWb.memToReg <= exMem.memToReg;
			memWb.destReg <= exMem.destReg;
		end
	end

	// observation port, writes to r0 are dropped
	assign wbOut.valid = memWb.regWrite && memWb.destReg != '0;
	assign wbOut.regAddr = memWb.destReg;
	assign wbOut.data = wbValue(memWb);

	// decode never asks for both
	assert property (@(posedge clk) disable iff (rst) !(exMem.memRead && exMem.memWrite));

endmodule

`default_nettype wire

//--- design/pipelineCpu.sv
`timescale 1ns/1ns
`default_nettype none

module pipelineCpu (
	input logic clk,
	input logic rst,
	input cpuPkg::progWrite_t progLoad,
	output cpuPkg::wbPort_t wbOut
);
	import cpuPkg::*;

	ifId_t ifId;
	idEx_t idEx;
	exMem_t exMem;
	memWb_t memWb;
	logic stall; // load-use
	fwdSel_e fwdA, fwdB;

	fetchStage fetch (
		.clk (clk),
		.rst (rst),
		.progLoad (progLoad),
		.stall (stall),
		.ifId (ifId)
	);

	decodeStage decode (
		.clk (clk),
		.rst (rst),
		.ifId (ifId),
		.stall (stall),
		.memWb (memWb), // register write port
		.idEx (idEx)
	);

	hazardUnit hazard (
		.idEx (idEx),
		.ifId (ifId),
		.exMem (exMem),
		.memWb (memWb),
		.stall (stall),
		.fwdA (fwdA),
		.fwdB (fwdB)
	);

	executeStage execute (
		.clk (clk),
		.rst (rst),
		.idEx (idEx),
		.fwdA (fwdA),
		.fwdB (fwdB),
		.memWb (memWb), // forwarding source
		.exMem (exMem)
	);

	memoryStage memory (
		.clk (clk),
		.rst (rst),
		.exMem (exMem),
		.memWb (memWb),
		.wbOut (wbOut)
	);

endmodule

`default_nettype wire

//--- include/cpuTbPrograms.svh
`ifndef CPU_TB_PROGRAMS_SVH
`define CPU_TB_PROGRAMS_SVH

localparam int NUM_TESTS = 5;
localparam int MAX_LEN = 12; // words per program
localparam int RESET_CYCLES = 3; // clean reset cycles after the image is loaded
localparam int WB_TIMEOUT = 100; // cycles allowed for the expected write-backs
localparam int QUIET_CYCLES = 10;

logic [XLEN-1:0] progImage [NUM_TESTS][MAX_LEN]; // imem image, rest of imem is zero
logic progRand [NUM_TESTS][MAX_LEN]; // imm[14:0] replaced by $random, sign kept
int progLen [NUM_TESTS];

function automatic logic [XLEN-1:0] encR(funct_e fn, int rd, int rs, int rt);
	return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn};
endfunction

function automatic logic [XLEN-1:0] encI(opcode_e op, int rt, int rs, int imm);
	return {op, 5'(rs), 5'(rt), 16'(imm)};
endfunction

task automatic addInstr(input int t, input logic [XLEN-1:0] w, input logic rnd);
	progImage[t][progLen[t]] = w;
	progRand[t][progLen[t]] = rnd;
	progLen[t]++;
endtask

task automatic buildPrograms();
	for (int t = 0; t < NUM_TESTS; t++)
	begin
		progLen[t] = 0;
		for (int i = 0; i < MAX_LEN; i++)
		begin
			progImage[t][i] = '0;
			progRand[t][i] = 1'b0;
		end
	end
	// test 0: every ALU op, slt both ways
	addInstr(0, encI(OP_ADDI, 1, 0, 1), 1); // r1 positive
	addInstr(0, encI(OP_ADDI, 2, 0, -1), 1); // r2 negative
	addInstr(0, encR(FN_ADD, 3, 1, 2), 0);
	addInstr(0, encR(FN_SUB, 4, 1, 2), 0);
	addInstr(0, encR(FN_AND, 5, 1, 2), 0);
	addInstr(0, encR(FN_OR, 6, 1, 2), 0);
	addInstr(0, encR(FN_SLT, 7, 1, 2), 0);
	addInstr(0, encR(FN_SLT, 8, 2, 1), 0);
	// test 1: dependencies at distance 1 and 2
	addInstr(1, encI(OP_ADDI, 1, 0, 1), 1);
	addInstr(1, encI(OP_ADDI, 2, 1, -1), 1);
	addInstr(1, encR(FN_ADD, 3, 1, 2), 0);
	addInstr(1, encR(FN_SUB, 4, 3, 1), 0);
	addInstr(1, 32'h0, 0);
	addInstr(1, encR(FN_OR, 5, 4, 3), 0);
	addInstr(1, encR(FN_SLT, 6, 5, 4), 0);
	// test 2: sw then lw, store data forwarded
	addInstr(2, encI(OP_ADDI, 1, 0, 1), 1); // base
	addInstr(2, encI(OP_ADDI, 2, 0, -1), 1);
	addInstr(2, encI(OP_SW, 2, 1, 4), 0);
	addInstr(2, encI(OP_LW, 3, 1, 4), 0);
	addInstr(2, 32'h0, 0);
	addInstr(2, encR(FN_ADD, 4, 3, 2), 0);
	addInstr(2, encR(FN_ADD, 6, 2, 2), 0);
	addInstr(2, encI(OP_SW, 6, 1, 8), 0);
	addInstr(2, encI(OP_LW, 7, 1, 8), 0);
	// test 3: load-use on rs, rt and store data
	addInstr(3, encI(OP_ADDI, 1, 0, 1), 1);
	addInstr(3, encI(OP_ADDI, 2, 0, -1), 1);
	addInstr(3, encI(OP_SW, 2, 1, 0), 0);
	addInstr(3, encI(OP_LW, 3, 1, 0), 0);
	addInstr(3, encR(FN_ADD, 4, 3, 1), 0);
	addInstr(3, encI(OP_LW, 5, 1, 0), 0);
	addInstr(3, encR(FN_SUB, 6, 1, 5), 0);
	addInstr(3, encI(OP_LW, 7, 1, 0), 0);
	addInstr(3, encI(OP_SW, 7, 1, 1), 0);
	addInstr(3, encI(OP_LW, 8, 1, 1), 0);
	// test 4: r0 as destination and source
	addInstr(4, encI(OP_ADDI, 0, 0, 1), 1);
	addInstr(4, encI(OP_ADDI, 1, 0, -1), 1);
	addInstr(4, encR(FN_ADD, 2, 0, 1), 0);
	addInstr(4, encI(OP_LW, 0, 1, 0), 0);
	addInstr(4, encR(FN_ADD, 3, 0, 1), 0);
	addInstr(4, encR(FN_OR, 4, 1, 0), 0);
	addInstr(4, encR(FN_ADD, 0, 1, 1), 0);
	addInstr(4, encR(FN_SUB, 5, 0, 1), 0);
endtask

`endif

//--- tb/cpuTb.sv
`timescale 1ns/1ns
`default_nettype none

module cpuTb;
	import cpuPkg::*;

	`include "cpuTbPrograms.svh"

	logic clk = 1'b0;
	logic rst;
	progWrite_t progLoad;
	wbPort_t wbOut;

	integer seed;
	logic [XLEN-1:0] refRegs [32];
	logic [XLEN-1:0] refMem [DMEM_DEPTH]; // kept across tests, like the DUT's
	logic [REG_ADDR_W-1:0] expReg [$];
	logic [XLEN-1:0] expData [$];
	int testErrors;
	int totalErrors = 0;
	int failedTests = 0;
	int checkedWbs = 0;

	pipelineCpu UUT (
		.clk (clk),
		.rst (rst),
		.progLoad (progLoad),
		.wbOut (wbOut)
	);

	always #2 clk = ~clk; // 4 ns

	task automatic randomizeImmediates();
		logic [31:0] r;
		for (int t = 0; t < NUM_TESTS; t++)
			for (int i = 0; i < progLen[t]; i++)
				if (progRand[t][i])
				begin
					r = $random(seed);
					progImage[t][i][14:0] = r[14:0];
				end
	endtask

	// ISA reference, writes to r0 are dropped
	task automatic recordWrite(input logic [REG_ADDR_W-1:0] dest, input logic [XLEN-1:0] val);
		if (dest != '0)
		begin
			refRegs[dest] = val;
			expReg.push_back(dest);
			expData.push_back(val);
		end
	endtask

	task automatic runReference(input int t);
		logic [XLEN-1:0] w, a, b, imm, addr;
		logic [REG_ADDR_W-1:0] rt, rd;
		expReg.delete();
		expData.delete();
		for (int r = 0; r < 32; r++)
			refRegs[r] = '0;
		for (int i = 0; i < progLen[t]; i++)
		begin
			w = progImage[t][i];
			a = refRegs[w[25:21]];
			b = refRegs[w[20:16]];
			rt = w[20:16];
			rd = w[15:11];
			imm = {{16{w[15]}}, w[15:0]};
			addr = a + imm; // word index in the low bits
			case (w[31:26])
				OP_RTYPE:
					case (w[5:0])
						FN_ADD: recordWrite(rd, a + b);
						FN_SUB: recordWrite(rd, a - b);
						FN_AND: recordWrite(rd, a & b);
						FN_OR: recordWrite(rd, a | b);
						FN_SLT: recordWrite(rd, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
						default: ; // nop
					endcase
				OP_ADDI: recordWrite(rt, addr);
				OP_LW: recordWrite(rt, refMem[addr[DMEM_ADDR_W-1:0]]);
				OP_SW: refMem[addr[DMEM_ADDR_W-1:0]] = b;
				default: ;
			endcase
		end
	endtask

	// whole imem rewritten so no word of an earlier test survives
	task automatic resetAndLoad(input int t);
		@(posedge clk);
		rst <= 1'b1;
		for (int i = 0; i < IMEM_DEPTH; i++)
		begin
			progLoad.we <= 1'b1;
			progLoad.addr <= IMEM_ADDR_W'(i);
			progLoad.data <= (i < progLen[t]) ? progImage[t][i] : '0;
			@(posedge clk);
		end
		progLoad <= '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;
	endtask

	task automatic checkEvent(input int t, input int idx);
		assert (wbOut.regAddr === expReg[idx]) else
		begin
			$display("FAILED test %0d write %0d: wbOut.regAddr got 0x%h expected 0x%h",
				t, idx, wbOut.regAddr, expReg[idx]);
			testErrors++;
		end
		assert (wbOut.data === expData[idx]) else
		begin
			$display("FAILED test %0d write %0d: wbOut.data got 0x%h expected 0x%h",
				t, idx, wbOut.data, expData[idx]);
			testErrors++;
		end
	endtask

	task automatic collectWriteBacks(input int t);
		int got;
		int cycles;
		got = 0;
		cycles = 0;
		while (got < expReg.size() && cycles < WB_TIMEOUT)
		begin
			@(negedge clk); // outputs settled
			cycles++;
			if (wbOut.valid)
			begin
				checkEvent(t, got);
				got++;
			end
		end
		checkedWbs += got;
		assert (got == expReg.size()) else
		begin
			$display("test %0d timed out after %0d cycles with %0d of %0d write-backs seen",
				t, cycles, got, expReg.size());
			testErrors++;
		end
		// nothing more may retire
		for (int i = 0; i < QUIET_CYCLES; i++)
		begin
			@(negedge clk);
			assert (!wbOut.valid) else
			begin
				$display("test %0d saw an extra write-back to register %0d after the program",
					t, wbOut.regAddr);
				testErrors++;
			end
		end
	endtask

	initial
	begin
		rst = 1'b1;
		progLoad = '0;
		seed = 32'h23192ea1;
		buildPrograms();
		randomizeImmediates();
		for (int t = 0; t < NUM_TESTS; t++)
		begin
			testErrors = 0;
			runReference(t);
			resetAndLoad(t);
			collectWriteBacks(t);
			$display("test %0d: %0d write-backs expected, %0d errors", t, expReg.size(),
				testErrors);
			if (testErrors != 0)
				failedTests++;
			totalErrors += testErrors;
		end
		$display("tests %0d, failed %0d, write-backs checked %0d, errors %0d", NUM_TESTS,
			failedTests, checkedWbs, totalErrors);
		if (totalErrors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
design/cpuPkg.sv
design/fetchStage.sv
design/decodeStage.sv
design/hazardUnit.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineCpu.sv
tb/cpuTb.sv
